//--- hdl/glue_pkg.sv
// shared bus struct, region enum and address map for the z180 glue; import where needed

package glue_pkg;

    // **************************************************
    // address map
    // **************************************************

    // first address served by the static RAM, everything below is boot ROM
    localparam logic [19:0] ROM_LIMIT = 20'h00200;

    // led latch sits inside RAM space, full 20 bit compare
    localparam logic [19:0] LED_ADDR = 20'h0FFFF;

    // default ROM address width, 512 bytes
    localparam int ROM_ADDR_BITS = 9;

    // **************************************************
    // bus types
    // **************************************************

    // one sampled CPU bus state
    // strobes are stored active high, inverted from the *_n pins
    typedef struct packed {
        logic [19:0] addr;  // full physical address from the MMU
        logic [7:0]  data;  // write data from the CPU
        logic        mreq;  // memory request
        logic        rd;    // read strobe
        logic        wr;    // write strobe
        logic        m1;    // opcode fetch cycle
    } cpu_bus_t;

    // which memory a sampled cycle goes to
    typedef enum logic [1:0] {
        region_none = 2'd0, // no memory request this cycle
        region_rom  = 2'd1, // boot ROM, below ROM_LIMIT
        region_ram  = 2'd2  // external static RAM
    } region_e;

endpackage : glue_pkg

//--- hdl/boot_rom.sv
// boot ROM with registered read data, image loaded from rom.hex at elaboration

`timescale 1ns/1ps

module boot_rom #(
    parameter int ROM_ADDR_BITS = glue_pkg::ROM_ADDR_BITS  // set by the top level
) (
    input  logic                     hwclk,
    input  logic [ROM_ADDR_BITS-1:0] addr,   // raw CPU address bits
    output logic [7:0]               data    // valid one edge after addr
);

    localparam int ROM_BYTES = 2 ** ROM_ADDR_BITS;

    // **************************************************
    // storage
    // **************************************************

    logic [7:0] mem [0:ROM_BYTES-1];

    // image is 16 bytes per line in hex
    initial begin
        $readmemh("rom.hex", mem);
    end

    // **************************************************
    // read port
    // **************************************************

    // sampled on the same edge the decoder loads bus_q,
    // so data lines up with the registered bus
    always_ff @(posedge hwclk) begin
        data <= mem[addr];  // one edge of read latency
    end

endmodule : boot_rom

//--- hdl/bus_decode.sv
// registers the CPU bus, classifies each cycle and drives RAM enables and data direction

`timescale 1ns/1ps

module bus_decode
    import glue_pkg::*;
(
    input  logic       hwclk,
    input  logic       rst,
    input  logic [19:0] a,         // CPU address
    input  logic [7:0] d_in,       // data from the CPU
    input  logic       mreq_n,
    input  logic       rd_n,
    input  logic       wr_n,
    input  logic       m1_n,
    input  logic [7:0] rom_data,   // already aligned with bus_q
    output cpu_bus_t   bus_q,      // sampled bus, one cycle behind the pins
    output logic       ce_n,       // static RAM chip enable
    output logic       oe_n,       // static RAM output enable
    output logic       we_n,       // static RAM write enable
    output logic [7:0] d_out,      // data toward the CPU
    output logic       d_oe        // glue drives the data bus
);

    cpu_bus_t bus_d;     // pins packed, active high strobes
    region_e  region_d;  // region of the cycle being sampled

    // **************************************************
    // classify
    // **************************************************

    function automatic region_e classify(input cpu_bus_t b);
        region_e r;
        if (!b.mreq) begin
            r = region_none;                   // io or idle
        end else if (b.addr < ROM_LIMIT) begin
            r = region_rom;
        end else begin
            r = region_ram;                    // includes the led address
        end
        return r;
    endfunction

    always_comb begin
        bus_d.addr = a;
        bus_d.data = d_in;
        bus_d.mreq = ~mreq_n;
        bus_d.rd   = ~rd_n;
        bus_d.wr   = ~wr_n;
        bus_d.m1   = ~m1_n;
        region_d   = classify(bus_d);
    end

    // **************************************************
    // registers
    // **************************************************

    // whole bus state, one cycle behind the pins
    always_ff @(posedge hwclk) begin
        bus_q <= bus_d;
    end

    // enables register on the same edge as bus_q, so one cycle from the pins
    always_ff @(posedge hwclk) begin
        if (rst) begin
            ce_n <= 1'b1;
            oe_n <= 1'b1;
            we_n <= 1'b1;
            d_oe <= 1'b0;
        end else begin
            ce_n <= (region_d != region_ram);
            oe_n <= ~(bus_d.mreq & bus_d.rd);  // also asserted on ROM reads, ce_n keeps RAM off
            we_n <= ~(bus_d.mreq & bus_d.wr);
            d_oe <= (region_d == region_rom) & bus_d.rd;
        end
    end

    // ROM byte only while we own the bus
    assign d_out = d_oe ? rom_data : 8'h00;

    // **************************************************
    // checks
    // **************************************************

    // glue and RAM must never both drive the data bus
    a_no_contention: assert property (@(posedge hwclk) disable iff (rst)
        !(d_oe && !ce_n));

    // a RAM write with the glue driving would corrupt the written byte
    a_no_drive_on_write: assert property (@(posedge hwclk) disable iff (rst)
        !(d_oe && !we_n));

endmodule : bus_decode

//--- hdl/led_port.sv
// led latch for writes to LED_ADDR, shows the byte once the write cycle ends

`timescale 1ns/1ps

module led_port
    import glue_pkg::*;
(
    input  logic       hwclk,
    input  logic       rst,
    input  cpu_bus_t   bus_q,   // registered bus from the decoder
    output logic [7:0] led
);

    logic       hit;       // sampled cycle is a write to the led address
    logic       busy;      // led write under way
    logic [7:0] pending;   // latest data seen during the write

    assign hit = bus_q.mreq & bus_q.wr & (bus_q.addr == LED_ADDR);

    // **************************************************
    // capture
    // **************************************************

    // data may settle late in the cycle, keep the last sample
    always_ff @(posedge hwclk) begin
        if (hit) begin
            pending <= bus_q.data;
        end
    end

    always_ff @(posedge hwclk) begin
        if (rst) begin
            busy <= 1'b0;
            led  <= 8'h00;
        end else if (hit) begin
            busy <= 1'b1;
        end else if (busy && !bus_q.wr) begin
            // write strobe gone so the last sampled byte goes out
            busy <= 1'b0;
            led  <= pending;
        end
    end

    // **************************************************
    // checks
    // **************************************************

    // led only moves after the write strobe drops
    a_led_stable_in_write: assert property (@(posedge hwclk) disable iff (rst)
        hit |=> $stable(led));

endmodule : led_port

//--- hdl/cpu_clock_gen.sv
// divides hwclk down to the CPU clock and synchronizes the push-button reset

`timescale 1ns/1ps

module cpu_clock_gen #(
    parameter int CLK_DIV_BITS = 1    // extal period is 2**CLK_DIV_BITS hwclk cycles
) (
    input  logic hwclk,
    input  logic rst,
    input  logic s1_n,      // push-button, low when pressed, async to hwclk
    output logic extal,     // CPU clock
    output logic reset_n    // CPU reset, active low
);

    logic [CLK_DIV_BITS-1:0] ctr;       // free running divider
    logic [1:0]              sync_q;    // button synchronizer, [1] is the output

    // **************************************************
    // clock divider
    // **************************************************

    always_ff @(posedge hwclk) begin
        if (rst) begin
            ctr <= '0;
        end else begin
            ctr <= ctr + 1'b1;
        end
    end

    assign extal = ctr[CLK_DIV_BITS-1];  // top bit toggles every half period

    // **************************************************
    // reset synchronizer
    // **************************************************

    // two flops against metastability, cleared so the CPU stays in reset
    always_ff @(posedge hwclk) begin
        if (rst) begin
            sync_q <= 2'b00;
        end else begin
            sync_q <= {sync_q[0], s1_n};
        end
    end

    assign reset_n = sync_q[1];

    // board reset must reach the CPU on the next edge
    a_reset_follows_rst: assert property (@(posedge hwclk)
        rst |=> !reset_n);

endmodule : cpu_clock_gen

//--- hdl/z180_glue_top.sv
// top level of the z180 bus glue, connects decoder, boot ROM, led port and clock/reset to pins

`timescale 1ns/1ps

module z180_glue_top
    import glue_pkg::*;
#(
    parameter int ROM_ADDR_BITS = glue_pkg::ROM_ADDR_BITS,  // boot ROM size, 512 bytes
    parameter int CLK_DIV_BITS  = 1                          // CPU clock divider width
) (
    // **************************************************
    // board
    // **************************************************
    input  logic        hwclk,     // board oscillator
    input  logic        rst,       // glue reset, synchronous
    input  logic        s1_n,      // reset push-button
    output logic [7:0]  led,
    output logic        extal,     // CPU clock input
    output logic        reset_n,   // CPU reset

    // **************************************************
    // CPU bus
    // **************************************************
    input  logic [19:0] a,
    input  logic [7:0]  d_in,      // split data bus, tristate is in the board wrapper
    output logic [7:0]  d_out,
    output logic        d_oe,
    input  logic        mreq_n,
    input  logic        rd_n,
    input  logic        wr_n,
    input  logic        m1_n,

    // static RAM
    output logic        ce_n,
    output logic        oe_n,
    output logic        we_n
);

    cpu_bus_t   bus_q;     // sampled bus, decoder to led port
    logic [7:0] rom_data;  // ROM byte for the sampled address

    // bus sampling, RAM enables and data direction
    bus_decode u_decode (
        .hwclk    (hwclk),
        .rst      (rst),
        .a        (a),
        .d_in     (d_in),
        .mreq_n   (mreq_n),
        .rd_n     (rd_n),
        .wr_n     (wr_n),
        .m1_n     (m1_n),
        .rom_data (rom_data),
        .bus_q    (bus_q),
        .ce_n     (ce_n),
        .oe_n     (oe_n),
        .we_n     (we_n),
        .d_out    (d_out),
        .d_oe     (d_oe)
    );

    // raw address bits, read on the edge that loads bus_q
    boot_rom #(
        .ROM_ADDR_BITS (ROM_ADDR_BITS)
    ) u_rom (
        .hwclk (hwclk),
        .addr  (a[ROM_ADDR_BITS-1:0]),
        .data  (rom_data)
    );

    led_port u_led (
        .hwclk (hwclk),
        .rst   (rst),
        .bus_q (bus_q),
        .led   (led)
    );

    cpu_clock_gen #(
        .CLK_DIV_BITS (CLK_DIV_BITS)
    ) u_clk (
        .hwclk   (hwclk),
        .rst     (rst),
        .s1_n    (s1_n),
        .extal   (extal),
        .reset_n (reset_n)
    );

endmodule : z180_glue_top

//--- tests/tb_z180_glue.sv
// testbench for the z180 glue: random CPU bus cycles from a fixed seed, checked against a model

`timescale 1ns/1ps

module tb_z180_glue
    import glue_pkg::*;
;

    localparam int CLK_DIV_BITS = 1;     // DUT default
    localparam int N_ROM = 300;          // ROM reads
    localparam int N_RAM = 300;          // RAM cycles, 1 to 4 hwclk each
    localparam int N_LED = 120;          // writes, each followed by 3 idle cycles
    // worst case length of the run in hwclk cycles
    localparam int MAX_CYCLES = 3 + N_ROM + 4 * N_RAM + 7 * N_LED;
    localparam real TIMEOUT_NS = MAX_CYCLES * 4.0 + 400.0;

    logic        hwclk;
    logic        rst;
    logic        s1_n;
    logic [19:0] a;
    logic [7:0]  d_in;
    logic        mreq_n;
    logic        rd_n;
    logic        wr_n;
    logic        m1_n;
    logic [7:0]  d_out;
    logic        d_oe;
    logic        ce_n;
    logic        oe_n;
    logic        we_n;
    logic [7:0]  led;
    logic        extal;
    logic        reset_n;

    logic [7:0]              rom_model [0:511];  // expected ROM image
    logic [31:0]             lcg_state;
    logic [CLK_DIV_BITS-1:0] model_ctr;          // expected divider count
    logic [1:0]              model_sync;         // expected button synchronizer
    logic [7:0]              model_led;          // data of the last write to LED_ADDR
    int                      errors;

    z180_glue_top u_dut (
        .hwclk   (hwclk),
        .rst     (rst),
        .s1_n    (s1_n),
        .led     (led),
        .extal   (extal),
        .reset_n (reset_n),
        .a       (a),
        .d_in    (d_in),
        .d_out   (d_out),
        .d_oe    (d_oe),
        .mreq_n  (mreq_n),
        .rd_n    (rd_n),
        .wr_n    (wr_n),
        .m1_n    (m1_n),
        .ce_n    (ce_n),
        .oe_n    (oe_n),
        .we_n    (we_n)
    );

    // 4 ns period
    always begin
        hwclk = 1'b0;
        #2;
        hwclk = 1'b1;
        #2;
    end

    // **************************************************
    // helpers
    // **************************************************

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;  // low bits are weak, callers use the top ones
    endfunction

    task automatic stop_on_error();
        errors++;
        $display("Some tests failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_bit(input string what, input logic got, input logic want);
        assert (got === want) else begin
            $display("Fail at %0.1f ns: %s is %b, expected %b", $realtime, what, got, want);
            stop_on_error();
        end
    endtask

    task automatic check_byte(input string what, input logic [7:0] got, input logic [7:0] want);
        assert (got === want) else begin
            $display("Fail at %0.1f ns: %s is %h, expected %h", $realtime, what, got, want);
            stop_on_error();
        end
    endtask

    // put one bus state on the pins
    task automatic drive_bus(input logic [19:0] addr, input logic [7:0] data,
                             input logic mreq, input logic rd, input logic wr);
        logic [31:0] r;
        r      = lcg_next();
        a      = addr;
        d_in   = data;
        mreq_n = ~mreq;
        rd_n   = ~rd;
        wr_n   = ~wr;
        m1_n   = ~(mreq & rd & r[31]);           // some reads are opcode fetches
        if (mreq && wr && addr == LED_ADDR) begin
            model_led = data;                    // led must end up with this byte
        end
    endtask

    // one hwclk cycle: expected values come from the pins the DUT samples at this edge
    task automatic tick();
        logic       mreq;
        logic       below;
        logic       e_ce_n;
        logic       e_oe_n;
        logic       e_we_n;
        logic       e_d_oe;
        logic [8:0] ra;
        logic [31:0] r;
        mreq   = ~mreq_n;
        below  = (a < ROM_LIMIT);
        ra     = a[8:0];
        e_ce_n = rst | ~(mreq & ~below);         // RAM from ROM_LIMIT up
        e_oe_n = rst | ~(mreq & ~rd_n);
        e_we_n = rst | ~(mreq & ~wr_n);
        e_d_oe = ~rst & mreq & ~rd_n & below;    // glue drives only ROM reads
        if (rst) begin
            model_ctr  = '0;
            model_sync = 2'b00;                  // CPU held in reset
        end else begin
            model_ctr  = model_ctr + 1'b1;
            model_sync = {model_sync[0], s1_n};  // two flops of delay
        end
        @(posedge hwclk);
        #0.5;
        check_bit("ce_n", ce_n, e_ce_n);
        check_bit("oe_n", oe_n, e_oe_n);
        check_bit("we_n", we_n, e_we_n);
        check_bit("d_oe", d_oe, e_d_oe);
        check_bit("extal", extal, model_ctr[CLK_DIV_BITS-1]);
        check_bit("reset_n", reset_n, model_sync[1]);
        if (e_d_oe) begin
            check_byte("d_out", d_out, rom_model[ra]);
        end
        r = lcg_next();
        if (r[31:30] == 2'b00) begin
            s1_n = ~s1_n;                        // button bounces now and then
        end
    endtask

    // **************************************************
    // stimulus
    // **************************************************

    initial begin
        logic [31:0] r;
        logic [19:0] addr;
        logic        rd;
        logic        wr;
        int          len;
        lcg_state  = 32'h6f63_8215;
        errors     = 0;
        model_ctr  = '0;
        model_sync = 2'b00;
        model_led  = 8'h00;
        rst        = 1'b1;
        s1_n       = 1'b1;
        drive_bus(20'h00000, 8'h00, 1'b0, 1'b0, 1'b0);
        $readmemh("rom.hex", rom_model);

        // reset for 2 cycles, then one more right after release
        repeat (2) begin
            tick();
            check_byte("led", led, 8'h00);
        end
        rst = 1'b0;
        tick();
        check_byte("led", led, 8'h00);

        // ROM reads back to back
        for (int i = 0; i < N_ROM; i++) begin
            r = lcg_next();
            drive_bus({11'h000, r[31:23]}, r[15:8], 1'b1, 1'b1, 1'b0);
            tick();
        end

        // RAM cycles: idle, read, write or a bare mreq
        for (int i = 0; i < N_RAM; i++) begin
            r    = lcg_next();
            addr = r[31:12] | ROM_LIMIT;
            rd   = (r[11:10] == 2'b01);
            wr   = (r[11:10] == 2'b10);
            len  = int'(r[9:8]) + 1;
            drive_bus(addr, r[7:0], r[11:10] != 2'b00, rd, wr);
            repeat (len) tick();
        end

        // led writes mixed with other RAM writes
        for (int i = 0; i < N_LED; i++) begin
            r    = lcg_next();
            addr = r[31] ? LED_ADDR : (r[30:11] | ROM_LIMIT);
            len  = int'(r[9:8]) + 1;
            drive_bus(addr, r[7:0], 1'b1, 1'b0, 1'b1);
            repeat (len) tick();
            drive_bus(addr, r[7:0], 1'b0, 1'b0, 1'b0);  // write strobe released
            repeat (3) tick();
            check_byte("led", led, model_led);
        end

        if (errors == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            $display("Some tests failed");
            $fatal(1, "errors found");
        end
    end

    // watchdog, the run must end well before this
    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired: the run did not finish in %0.1f ns", TIMEOUT_NS);
        $display("Some tests failed");
        $fatal(1, "timeout");
    end

endmodule : tb_z180_glue

//--- rom.hex
// 16 bytes per line; 0x000-0x0ff hold the low address byte, 0x100-0x1ff its inverse
00 01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f
10 11 12 13 14 15 16 17 18 19 1a 1b 1c 1d 1e 1f
20 21 22 23 24 25 26 27 28 29 2a 2b 2c 2d 2e 2f
30 31 32 33 34 35 36 37 38 39 3a 3b 3c 3d 3e 3f
40 41 42 43 44 45 46 47 48 49 4a 4b 4c 4d 4e 4f
50 51 52 53 54 55 56 57 58 59 5a 5b 5c 5d 5e 5f
60 61 62 63 64 65 66 67 68 69 6a 6b 6c 6d 6e 6f
70 71 72 73 74 75 76 77 78 79 7a 7b 7c 7d 7e 7f
80 81 82 83 84 85 86 87 88 89 8a 8b 8c 8d 8e 8f
90 91 92 93 94 95 96 97 98 99 9a 9b 9c 9d 9e 9f
a0 a1 a2 a3 a4 a5 a6 a7 a8 a9 aa ab ac ad ae af
b0 b1 b2 b3 b4 b5 b6 b7 b8 b9 ba bb bc bd be bf
c0 c1 c2 c3 c4 c5 c6 c7 c8 c9 ca cb cc cd ce cf
d0 d1 d2 d3 d4 d5 d6 d7 d8 d9 da db dc dd de df
e0 e1 e2 e3 e4 e5 e6 e7 e8 e9 ea eb ec ed ee ef
f0 f1 f2 f3 f4 f5 f6 f7 f8 f9 fa fb fc fd fe ff
ff fe fd fc fb fa f9 f8 f7 f6 f5 f4 f3 f2 f1 f0
ef ee ed ec eb ea e9 e8 e7 e6 e5 e4 e3 e2 e1 e0
df de dd dc db da d9 d8 d7 d6 d5 d4 d3 d2 d1 d0
cf ce cd cc cb ca c9 c8 c7 c6 c5 c4 c3 c2 c1 c0
bf be bd bc bb ba b9 b8 b7 b6 b5 b4 b3 b2 b1 b0
af ae ad ac ab aa a9 a8 a7 a6 a5 a4 a3 a2 a1 a0
9f 9e 9d 9c 9b 9a 99 98 97 96 95 94 93 92 91 90
8f 8e 8d 8c 8b 8a 89 88 87 86 85 84 83 82 81 80
7f 7e 7d 7c 7b 7a 79 78 77 76 75 74 73 72 71 70
6f 6e 6d 6c 6b 6a 69 68 67 66 65 64 63 62 61 60
5f 5e 5d 5c 5b 5a 59 58 57 56 55 54 53 52 51 50
4f 4e 4d 4c 4b 4a 49 48 47 46 45 44 43 42 41 40
3f 3e 3d 3c 3b 3a 39 38 37 36 35 34 33 32 31 30
2f 2e 2d 2c 2b 2a 29 28 27 26 25 24 23 22 21 20
1f 1e 1d 1c 1b 1a 19 18 17 16 15 14 13 12 11 10
0f 0e 0d 0c 0b 0a 09 08 07 06 05 04 03 02 01 00

//--- tb.f
hdl/glue_pkg.sv
hdl/boot_rom.sv
hdl/bus_decode.sv
hdl/led_port.sv
hdl/cpu_clock_gen.sv
hdl/z180_glue_top.sv
tests/tb_z180_glue.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
LINTFLAGS := --lint-only --timing
TB_TOP    := tb_z180_glue
RTL_TOP   := z180_glue_top
FILELIST  := tb.f
OBJ_DIR   := obj_dir
PASS_MSG  := All tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
